//--- cmdMessageRom.sv
module cmdMessageRom (
    input  robotCmdPkg::msgPos_t pos,
    output logic [7:0]           msgByte,
    output robotCmdPkg::msgLen_t msgLength
);

    robotCmdPkg::valueStr_t valL;                            // Left wheel value text
    robotCmdPkg::valueStr_t valR;                            // Right wheel value text
    int lenL;
    int lenR;
    int idx;
    int offSep;                                              // First byte of ,"R":
    int offR;                                                // First byte of right value
    int offSuf;                                              // Closing brace position
    int msgEnd;                                              // One past the newline

    // Value strings per command
    always_comb begin
        case (pos.cmd)
            robotCmdPkg::LEFT: begin
                valL = "-0.00";
                lenL = 5;
                valR = "0.12";
                lenR = 4;
            end
            robotCmdPkg::RIGHT: begin
                valL = "0.12";
                lenL = 4;
                valR = "-0.00";
                lenR = 5;
            end
            robotCmdPkg::SLOW: begin
                valL = "0.05";
                lenL = 4;
                valR = "0.05";
                lenR = 4;
            end
            robotCmdPkg::MEDIUM: begin
                valL = "0.25";
                lenL = 4;
                valR = "0.25";
                lenR = 4;
            end
            robotCmdPkg::FAST: begin
                valL = "0.5";
                lenL = 3;
                valR = "0.5";
                lenR = 3;
            end
            robotCmdPkg::REVERSE: begin
                valL = "-0.25";
                lenL = 5;
                valR = "-0.25";
                lenR = 5;
            end
            default: begin                                   // STOP and code 7
                valL = "0";
                lenL = 1;
                valR = "0";
                lenR = 1;
            end
        endcase
    end

    // Byte assembly, each segment indexed from its own right-aligned text
    always_comb begin
        idx    = int'(pos.index);
        offSep = robotCmdPkg::PrefixLen + lenL;
        offR   = offSep + robotCmdPkg::SepLen;
        offSuf = offR + lenR;
        msgEnd = offSuf + robotCmdPkg::SuffixLen;
        if (idx < robotCmdPkg::PrefixLen) begin
            msgByte = robotCmdPkg::MsgPrefix[(robotCmdPkg::PrefixLen - 1 - idx) * 8 +: 8];
        end else if (idx < offSep) begin
            msgByte = valL[(offSep - 1 - idx) * 8 +: 8];
        end else if (idx < offR) begin
            msgByte = robotCmdPkg::MsgSep[(offR - 1 - idx) * 8 +: 8];
        end else if (idx < offSuf) begin
            msgByte = valR[(offSuf - 1 - idx) * 8 +: 8];
        end else if (idx < msgEnd) begin
            msgByte = robotCmdPkg::MsgSuffix[(msgEnd - 1 - idx) * 8 +: 8];
        end else begin
            msgByte = 8'h00;                                 // Past the end
        end
    end

    assign msgLength = robotCmdPkg::msgLen_t'(msgEnd);

endmodule

//--- filelist.f
robotCmdPkg.sv
uartPkg.sv
cmdMessageRom.sv
uartTx.sv
msgSequencer.sv
robotLinkTop.sv
robotLinkProperties.sv
robotLinkTb.sv

//--- msgSequencer.sv
module msgSequencer (
    input  logic                   clk,
    input  logic                   rst,
    input  robotCmdPkg::driveCmd_t cmd,
    input  logic                   busy,
    input  logic [7:0]             msgByte,
    input  robotCmdPkg::msgLen_t   msgLength,
    output robotCmdPkg::msgPos_t   pos,
    output uartPkg::txReq_t        txReq,
    output logic                   msgDone,
    output robotCmdPkg::msgLen_t   msgLen
);

    typedef enum logic [1:0] {
        Latch,                                               // Take cmd, load byte 0
        Send,                                                // Load next byte
        WaitTx,                                              // Wait for frame end
        Gap                                                  // Idle between messages
    } state_t;

    state_t                                state;
    robotCmdPkg::driveCmd_t                curCmd;           // Command of message in flight
    robotCmdPkg::msgLen_t                  index;            // Current byte position
    logic [robotCmdPkg::GapCntWidth-1:0]   gapCnt;
    logic                                  startQ;
    logic [7:0]                            dataQ;
    logic                                  loadByte;
    logic                                  txIdle;
    logic                                  lastByte;

    // ROM sees the live command during Latch so byte 0 and length match it
    assign pos = '{cmd: (state == Latch) ? cmd : curCmd, index: index};
    assign txReq = '{start: startQ, data: dataQ};

    assign loadByte = (state == Latch) || (state == Send);
    assign txIdle   = !busy && !startQ;                      // Skip the strobe cycle itself
    assign lastByte = (index == msgLen - 1'b1);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state   <= Latch;
            curCmd  <= robotCmdPkg::STOP;
            index   <= '0;
            gapCnt  <= '0;
            startQ  <= 1'b0;
            msgDone <= 1'b0;
            msgLen  <= '0;
        end else begin
            startQ  <= loadByte;                             // Strobe follows each load
            msgDone <= 1'b0;
            case (state)
                Latch: begin
                    curCmd <= cmd;
                    msgLen <= msgLength;
                    state  <= WaitTx;
                end
                Send: begin
                    state <= WaitTx;
                end
                WaitTx: begin
                    if (txIdle) begin
                        if (lastByte) begin
                            msgDone <= 1'b1;                 // Newline has left the line
                            index   <= '0;
                            gapCnt  <= '0;
                            state   <= Gap;
                        end else begin
                            index <= index + 1'b1;
                            state <= Send;
                        end
                    end
                end
                Gap: begin
                    gapCnt <= gapCnt + 1'b1;
                    if (gapCnt == robotCmdPkg::GapLast) begin
                        state <= Latch;
                    end
                end
                default: begin
                    state <= Latch;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (loadByte) begin
            dataQ <= msgByte;                                // Byte for the next frame
        end
    end

endmodule

//--- robotCmdPkg.sv
package robotCmdPkg;

    // Drive command codes, code 7 has no name and reads as STOP
    typedef enum logic [2:0] {
        STOP    = 3'd0,
        LEFT    = 3'd1,
        RIGHT   = 3'd2,
        SLOW    = 3'd3,
        MEDIUM  = 3'd4,
        FAST    = 3'd5,
        REVERSE = 3'd6
    } driveCmd_t;

    localparam int PrefixLen   = 11;                        // {"T":1,"L":
    localparam int SepLen      = 5;                         // ,"R":
    localparam int SuffixLen   = 2;                         // Brace and newline
    localparam int ValueMaxLen = 5;                         // Longest value, -0.25
    localparam int MaxMsgLen   = PrefixLen + SepLen + SuffixLen + 2 * ValueMaxLen;
    localparam int LenWidth    = $clog2(MaxMsgLen + 1);     // 5 bits

    localparam logic [8*PrefixLen-1:0] MsgPrefix = "{\"T\":1,\"L\":";
    localparam logic [8*SepLen-1:0]    MsgSep    = ",\"R\":";
    localparam logic [8*SuffixLen-1:0] MsgSuffix = {8'h7D, 8'h0A};

    typedef logic [LenWidth-1:0]      msgLen_t;              // Lengths and byte positions
    typedef logic [8*ValueMaxLen-1:0] valueStr_t;            // Right-aligned ASCII value

    typedef struct packed {
        driveCmd_t cmd;                                      // Message select
        msgLen_t   index;                                    // Byte position, 0 first
    } msgPos_t;

    localparam int GapCycles   = 64;                         // Idle clocks between messages
    localparam int GapCntWidth = $clog2(GapCycles);
    localparam logic [GapCntWidth-1:0] GapLast = GapCntWidth'(GapCycles - 1);

endpackage

//--- robotLinkProperties.sv
module robotLinkProperties (
    input logic clk,
    input logic rst,
    input logic start,                                       // Transmit strobe
    input logic busy,                                        // Frame in progress
    input logic msgDone,                                     // End of message pulse
    input logic txd                                          // Serial line
);

    // Strobe only toward an idle transmitter
    startWhileIdle: assert property (@(posedge clk) disable iff (rst) start |-> !busy)
        else $error("Start strobe raised while the transmitter was busy");

    doneSingleCycle: assert property (@(posedge clk) disable iff (rst) msgDone |=> !msgDone)
        else $error("msgDone stayed high for more than one cycle");

    lineIdleHigh: assert property (@(posedge clk) disable iff (rst) !busy |-> txd)
        else $error("txd low while the transmitter was idle");

endmodule

// Sequencer strobe and done pulse meet the transmitter line here
bind robotLinkTop robotLinkProperties linkProps (
    .clk     (clk),
    .rst     (rst),
    .start   (txReq.start),
    .busy    (busy),
    .msgDone (msgDone),
    .txd     (txd)
);

//--- robotLinkTb.sv
module robotLinkTb;

    localparam int ByteTimeout = 2000;                       // Clocks allowed before a start bit
    localparam int DoneTimeout = 200;                        // Clocks from stop sample to msgDone

    logic                   clk;
    logic                   rst;
    robotCmdPkg::driveCmd_t cmd;
    logic                   txd;
    logic                   msgDone;
    robotCmdPkg::msgLen_t   msgLen;
    int                     doneCount;                       // msgDone pulses since reset
    int                     leadIdle;                        // High samples before byte 0

    robotLinkTop DUT (
        .clk     (clk),
        .rst     (rst),
        .cmd     (cmd),
        .txd     (txd),
        .msgDone (msgDone),
        .msgLen  (msgLen)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        if (rst) begin
            doneCount <= 0;
        end else if (msgDone) begin
            doneCount <= doneCount + 1;
        end
    end

    function automatic string leftValue(input logic [2:0] code);
        case (code)
            3'd1: return "-0.00";
            3'd2: return "0.12";
            3'd3: return "0.05";
            3'd4: return "0.25";
            3'd5: return "0.5";
            3'd6: return "-0.25";
            default: return "0";                             // STOP and code 7
        endcase
    endfunction

    function automatic string rightValue(input logic [2:0] code);
        case (code)
            3'd1: return "0.12";
            3'd2: return "-0.00";
            3'd3: return "0.05";
            3'd4: return "0.25";
            3'd5: return "0.5";
            3'd6: return "-0.25";
            default: return "0";
        endcase
    endfunction

    function automatic string expectedMsg(input logic [2:0] code);
        string msg;
        msg = {"{\"T\":1,\"L\":", leftValue(code), ",\"R\":", rightValue(code), "}\n"};
        return msg;
    endfunction

    task automatic failRun();
        $display("Something failed");
        $fatal(1, "Stopped at the first error");
    endtask

    task automatic checkValue(input string testName, input int expected, input int actual);
        if (expected !== actual) begin
            $display("Mismatch in %s: expected 'h%0h, actual 'h%0h", testName, expected, actual);
            failRun();
        end
    endtask

    task automatic driveCmd(input logic [2:0] code);
        @(posedge clk);
        cmd <= robotCmdPkg::driveCmd_t'(code);
    endtask

    // 8N1 receiver sampling at mid-bit on falling clock edges
    task automatic receiveByte(input string testName, output logic [7:0] data, output int idle);
        idle = 0;
        @(negedge clk);
        while (txd !== 1'b0) begin
            idle++;
            if (idle > ByteTimeout) begin
                $display("Timeout in %s: no start bit on txd", testName);
                failRun();
            end
            @(negedge clk);
        end
        repeat (uartPkg::ClksPerBit / 2) @(negedge clk);
        if (txd !== 1'b0) begin
            $display("In %s the start bit was shorter than half a bit", testName);
            failRun();
        end
        for (int b = 0; b < 8; b++) begin
            repeat (uartPkg::ClksPerBit) @(negedge clk);
            data[b] = txd;                                   // LSB first
        end
        repeat (uartPkg::ClksPerBit) @(negedge clk);
        if (txd !== 1'b1) begin
            $display("In %s the stop bit was low", testName);
            failRun();
        end
    endtask

    task automatic waitMsgDone(input string testName);
        int waited;
        waited = 0;
        @(negedge clk);
        while (msgDone !== 1'b1) begin
            if (txd !== 1'b1) begin
                $display("In %s txd went low before the message end pulse", testName);
                failRun();
            end
            waited++;
            if (waited > DoneTimeout) begin
                $display("Timeout in %s: no msgDone after the newline", testName);
                failRun();
            end
            @(negedge clk);
        end
        @(negedge clk);                                      // Pulse counter catches up
    endtask

    // One whole message with an optional cmd change after byte switchAt
    task automatic receiveMessage(input string testName, input logic [2:0] code,
                                  input int switchAt, input logic [2:0] nextCode);
        string      expMsg;
        logic [7:0] rxByte;
        int         idle;
        int         doneBefore;
        expMsg     = expectedMsg(code);
        doneBefore = doneCount;
        for (int i = 0; i < expMsg.len(); i++) begin
            receiveByte(testName, rxByte, idle);
            if (i == 0) begin
                leadIdle = idle;
            end
            checkValue($sformatf("%s byte %0d", testName, i), int'(expMsg[i]), int'(rxByte));
            if (i == switchAt) begin
                driveCmd(nextCode);                          // Lands mid message
            end
        end
        checkValue({testName, " msgLen"}, expMsg.len(), int'(msgLen));
        checkValue({testName, " pulses before end"}, 0, doneCount - doneBefore);
        waitMsgDone(testName);
        checkValue({testName, " pulses after end"}, 1, doneCount - doneBefore);
    endtask

    task automatic stopAfterReset();
        receiveMessage("stopAfterReset", 3'd0, -1, 3'd0);
    endtask

    task automatic everyCommandInGap();
        logic [2:0] code;
        for (int c = 1; c <= 6; c++) begin
            code = 3'(c);
            driveCmd(code);                                  // Inside the gap
            receiveMessage($sformatf("command %0d", c), code, -1, 3'd0);
        end
    endtask

    task automatic midMessageChange();
        driveCmd(3'd3);
        receiveMessage("midChange old", 3'd3, 5, 3'd5);     // SLOW then FAST from byte 5
        receiveMessage("midChange new", 3'd5, -1, 3'd0);
    endtask

    task automatic undefinedCodeAsStop();
        driveCmd(3'd7);
        receiveMessage("undefinedCode", 3'd7, -1, 3'd0);     // Reads as STOP
    endtask

    task automatic threeBackToBack();
        driveCmd(3'd4);
        for (int m = 0; m < 3; m++) begin
            receiveMessage($sformatf("backToBack %0d", m), 3'd4, -1, 3'd0);
            checkValue($sformatf("backToBack %0d idle gap", m), 1,
                       int'(leadIdle >= robotCmdPkg::GapCycles - 2));
        end
    endtask

    initial begin
        rst = 1'b1;
        cmd = robotCmdPkg::STOP;
        leadIdle = 0;
        repeat (8) @(posedge clk);
        rst <= 1'b0;
        stopAfterReset();
        everyCommandInGap();
        midMessageChange();
        undefinedCodeAsStop();
        threeBackToBack();
        $display("Everything OK");
        $finish;
    end

endmodule

//--- robotLinkTop.sv
module robotLinkTop (
    input  logic                   clk,
    input  logic                   rst,
    input  robotCmdPkg::driveCmd_t cmd,
    output logic                   txd,
    output logic                   msgDone,
    output robotCmdPkg::msgLen_t   msgLen
);

    robotCmdPkg::msgPos_t pos;                               // Sequencer to ROM address
    logic [7:0]           msgByte;
    robotCmdPkg::msgLen_t msgLength;
    uartPkg::txReq_t      txReq;                             // Byte and start strobe
    logic                 busy;                              // Frame in progress

    msgSequencer uSeq (
        .clk       (clk),
        .rst       (rst),
        .cmd       (cmd),
        .busy      (busy),
        .msgByte   (msgByte),
        .msgLength (msgLength),
        .pos       (pos),
        .txReq     (txReq),
        .msgDone   (msgDone),
        .msgLen    (msgLen)
    );

    cmdMessageRom uRom (
        .pos       (pos),
        .msgByte   (msgByte),
        .msgLength (msgLength)
    );

    uartTx uTx (
        .clk   (clk),
        .rst   (rst),
        .txReq (txReq),
        .txd   (txd),
        .busy  (busy)
    );

endmodule

//--- run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module robotLinkTb \
    -f filelist.f \
    -o robotLinkSim

./obj_dir/robotLinkSim

//--- uartPkg.sv
package uartPkg;

    localparam int ClksPerBit  = 16;                         // Scaled down for simulation
    localparam int ClkCntWidth = $clog2(ClksPerBit);
    localparam logic [ClkCntWidth-1:0] BitEnd = ClkCntWidth'(ClksPerBit - 1);

    localparam int FrameBits   = 10;                         // Start, 8 data, stop
    localparam int BitCntWidth = $clog2(FrameBits);
    localparam logic [BitCntWidth-1:0] StopBit = BitCntWidth'(FrameBits - 1);

    typedef struct packed {
        logic       start;                                   // One-cycle strobe
        logic [7:0] data;                                    // Byte to send
    } txReq_t;

endpackage

//--- uartTx.sv
module uartTx (
    input  logic            clk,
    input  logic            rst,
    input  uartPkg::txReq_t txReq,
    output logic            txd,
    output logic            busy
);

    logic [7:0]                      shiftReg;               // Data bits still to go
    logic [uartPkg::ClkCntWidth-1:0] clkCnt;                 // Clocks into current bit
    logic [uartPkg::BitCntWidth-1:0] bitCnt;                 // 0 start, 1..8 data, 9 stop
    logic                            bitEnd;
    logic                            load;

    assign bitEnd = (clkCnt == uartPkg::BitEnd);
    assign load   = !busy && txReq.start;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            txd    <= 1'b1;                                  // Line idles high
            busy   <= 1'b0;
            clkCnt <= '0;
            bitCnt <= '0;
        end else if (!busy) begin
            if (txReq.start) begin
                txd    <= 1'b0;                              // Start bit
                busy   <= 1'b1;
                clkCnt <= '0;
                bitCnt <= '0;
            end
        end else if (bitEnd) begin
            clkCnt <= '0;
            if (bitCnt == uartPkg::StopBit) begin
                busy <= 1'b0;                                // Stop bit done, txd stays high
            end else begin
                txd    <= shiftReg[0];                       // LSB first, then stop
                bitCnt <= bitCnt + 1'b1;
            end
        end else begin
            clkCnt <= clkCnt + 1'b1;
        end
    end

    // Ones shift in behind the data and form the stop bit
    always_ff @(posedge clk) begin
        if (load) begin
            shiftReg <= txReq.data;
        end else if (busy && bitEnd) begin
            shiftReg <= {1'b1, shiftReg[7:1]};
        end
    end

endmodule
